// ==== rtl/xadc_pkg.sv ====
package xadc_pkg;

	//////////////////////////////////////////////////
	// data path

	localparam int CODE_W = 16;                 // raw adc code width

	//////////////////////////////////////////////////
	// power-up timing, in clk cycles

	localparam int RESET_HOLD_CYCLES = 256;     // adc reset held after system reset
	localparam int SETTLE_CYCLES     = 256;     // wait after release before first read

	// one counter covers both phases, sized for the longer one
	localparam int SEQ_CNT_W = (RESET_HOLD_CYCLES > SETTLE_CYCLES) ?
		$clog2(RESET_HOLD_CYCLES) : $clog2(SETTLE_CYCLES);

	//////////////////////////////////////////////////
	// averaging

	localparam int AVG_LOG2 = 2;                // block of 4 samples

	//////////////////////////////////////////////////
	// over-temp thresholds, same encoding as the alarm regs

	localparam logic [CODE_W-1:0] TEMP_SET_CODE   = 16'hb5ed;  // ~85 C, raise flag
	localparam logic [CODE_W-1:0] TEMP_CLEAR_CODE = 16'ha93a;  // ~60 C, drop flag

endpackage

// ==== rtl/xadc_sequencer.sv ====
`timescale 1ns/1ps

module xadc_sequencer import xadc_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              adc_eoc,       // end of conversion pulse
	input  logic              drp_rdy,       // read data strobe from adc
	input  logic [CODE_W-1:0] drp_do,        // read data, valid with drp_rdy
	output logic              adc_reset,     // held high during power-up
	output logic              drp_en,        // one-cycle read request
	output logic              sample_valid,  // decimated sample strobe
	output logic [CODE_W-1:0] sample_code    // decimated sample
);

	//////////////////////////////////////////////////
	// state and counters

	typedef enum logic [1:0] {
		ST_HOLD,      // adc kept in reset
		ST_SETTLE,    // adc released, not yet usable
		ST_WAIT_EOC,  // idle until a conversion ends
		ST_WAIT_RDY   // read outstanding
	} state_t;

	localparam logic [SEQ_CNT_W-1:0] HOLD_LAST   = SEQ_CNT_W'(RESET_HOLD_CYCLES - 1);
	localparam logic [SEQ_CNT_W-1:0] SETTLE_LAST = SEQ_CNT_W'(SETTLE_CYCLES - 1);

	state_t               state;
	logic [SEQ_CNT_W-1:0] cnt;         // shared by hold and settle
	logic                 fwd_toggle;  // forward every second read

	assign adc_reset = (state == ST_HOLD);  // high straight out of reset

	//////////////////////////////////////////////////
	// control fsm

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state        <= ST_HOLD;
			cnt          <= '0;
			drp_en       <= 1'b0;
			sample_valid <= 1'b0;
			fwd_toggle   <= 1'b0;          // first read is dropped
		end else begin
			drp_en       <= 1'b0;          // pulses by default
			sample_valid <= 1'b0;

			case (state)
				ST_HOLD: begin
					cnt <= cnt + 1'b1;
					if (cnt == HOLD_LAST) begin
						cnt   <= '0;
						state <= ST_SETTLE;  // adc_reset drops here
					end
				end

				ST_SETTLE: begin
					cnt <= cnt + 1'b1;
					if (cnt == SETTLE_LAST) begin
						cnt   <= '0;
						state <= ST_WAIT_EOC;
					end
				end

				ST_WAIT_EOC: begin
					// request goes out the cycle after eoc, then we go busy
					if (drp_en)
						state <= ST_WAIT_RDY;
					else if (adc_eoc)
						drp_en <= 1'b1;
				end

				ST_WAIT_RDY: begin
					if (drp_rdy) begin
						sample_valid <= fwd_toggle;   // dual adc, new data every other read
						fwd_toggle   <= ~fwd_toggle;
						state        <= ST_WAIT_EOC;
					end
				end

				default: state <= ST_HOLD;
			endcase
		end
	end

	// read data capture
	always_ff @(posedge clk) begin
		if (state == ST_WAIT_RDY && drp_rdy)
			sample_code <= drp_do;
	end

	//////////////////////////////////////////////////
	// checks

	// no second request while one is pending
	a_no_en_busy: assert property (@(posedge clk) disable iff (!rst_n)
		state == ST_WAIT_RDY |-> !drp_en)
		else $error("drp_en raised with a read outstanding");

	// adc answers only reads we actually issued
	a_rdy_in_busy: assert property (@(posedge clk) disable iff (!rst_n)
		drp_rdy |-> state == ST_WAIT_RDY)
		else $error("drp_rdy seen with no read outstanding");

endmodule

// ==== rtl/sample_averager.sv ====
`timescale 1ns/1ps

module sample_averager import xadc_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sample_valid,  // input strobe
	input  logic [CODE_W-1:0] sample_code,   // input sample
	output logic              avg_valid,     // one pulse per block
	output logic [CODE_W-1:0] avg_code       // floor of block mean
);

	localparam int ACC_W = CODE_W + AVG_LOG2;  // room for a full block sum

	logic [ACC_W-1:0]    acc;       // running sum of the current block
	logic [AVG_LOG2-1:0] smp_cnt;   // samples taken so far
	logic [ACC_W-1:0]    blk_sum;   // sum including the incoming sample
	logic                blk_last;  // incoming sample closes the block

	assign blk_sum  = acc + ACC_W'(sample_code);
	assign blk_last = (smp_cnt == {AVG_LOG2{1'b1}});

	//////////////////////////////////////////////////
	// accumulate

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			acc       <= '0;
			smp_cnt   <= '0;
			avg_valid <= 1'b0;
		end else begin
			avg_valid <= 1'b0;
			if (sample_valid) begin
				smp_cnt <= smp_cnt + 1'b1;  // wraps at block end
				if (blk_last) begin
					acc       <= '0;        // next block starts fresh
					avg_valid <= 1'b1;
				end else begin
					acc <= blk_sum;
				end
			end
		end
	end

	// mean is the top bits of the sum
	always_ff @(posedge clk) begin
		if (sample_valid && blk_last)
			avg_code <= blk_sum[ACC_W-1:AVG_LOG2];
	end

	//////////////////////////////////////////////////
	// checks

	a_avg_after_smp: assert property (@(posedge clk) disable iff (!rst_n)
		avg_valid |-> $past(sample_valid))
		else $error("avg_valid without a preceding sample");

endmodule

// ==== rtl/limit_monitor.sv ====
`timescale 1ns/1ps

module limit_monitor import xadc_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              avg_valid,  // new average strobe
	input  logic [CODE_W-1:0] avg_code,   // averaged temp code
	output logic              over_temp   // hysteresis flag
);

	logic hit_set;    // at or above the raise threshold
	logic hit_clear;  // at or below the drop threshold

	assign hit_set   = (avg_code >= TEMP_SET_CODE);
	assign hit_clear = (avg_code <= TEMP_CLEAR_CODE);

	//////////////////////////////////////////////////
	// flag update

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			over_temp <= 1'b0;
		end else if (avg_valid) begin
			if (hit_set)
				over_temp <= 1'b1;
			else if (hit_clear)
				over_temp <= 1'b0;
			// middle band keeps the old value
		end
	end

	//////////////////////////////////////////////////
	// checks

	// flag only moves on a fresh average
	a_flag_on_avg: assert property (@(posedge clk) disable iff (!rst_n)
		$changed(over_temp) |-> $past(avg_valid))
		else $error("over_temp changed without a new average");

endmodule

// ==== rtl/xadc_monitor_top.sv ====
`timescale 1ns/1ps

module xadc_monitor_top import xadc_pkg::*; (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              adc_eoc,       // from adc
	input  logic              drp_rdy,       // from adc
	input  logic [CODE_W-1:0] drp_do,        // from adc
	output logic              adc_reset,     // to adc
	output logic              drp_en,        // to adc
	output logic              sample_valid,  // decimated raw stream
	output logic [CODE_W-1:0] sample_code,
	output logic              avg_valid,     // block means
	output logic [CODE_W-1:0] avg_code,
	output logic              over_temp      // alarm flag
);

	//////////////////////////////////////////////////
	// adc control and decimation

	xadc_sequencer u_seq (
		.clk          (clk),
		.rst_n        (rst_n),
		.adc_eoc      (adc_eoc),
		.drp_rdy      (drp_rdy),
		.drp_do       (drp_do),
		.adc_reset    (adc_reset),
		.drp_en       (drp_en),
		.sample_valid (sample_valid),
		.sample_code  (sample_code)
	);

	//////////////////////////////////////////////////
	// block mean

	sample_averager u_avg (
		.clk          (clk),
		.rst_n        (rst_n),
		.sample_valid (sample_valid),
		.sample_code  (sample_code),
		.avg_valid    (avg_valid),
		.avg_code     (avg_code)
	);

	// over-temp with hysteresis
	limit_monitor u_lim (
		.clk       (clk),
		.rst_n     (rst_n),
		.avg_valid (avg_valid),
		.avg_code  (avg_code),
		.over_temp (over_temp)
	);

endmodule

// ==== testbench/tb_adc_model.sv ====
`timescale 1ns/1ps

module tb_adc_model import xadc_pkg::*; #(
	parameter int EOC_PERIOD = 40,      // clk cycles between conversions
	parameter int READ_LAT   = 5,       // drp_en seen to drp_rdy, in cycles
	parameter int NUM_READS  = 64       // conversions served before going quiet
) (
	input  logic              clk,
	input  logic              adc_reset,
	input  logic              drp_en,
	input  logic [CODE_W-1:0] code_in,    // code returned by the next read
	output logic              adc_eoc,
	output logic              drp_rdy,
	output logic [CODE_W-1:0] drp_do,
	output int                req_count   // reads requested so far
);

	localparam int EXTRA_EOC_AT = 2;      // stray eoc inside read latency

	int                eoc_cnt;         // conversion timer
	int                lat_cnt;         // cycles into the current read
	logic              busy;            // read outstanding
	logic [CODE_W-1:0] held_code;       // captured at request time

	// everything moves on the falling edge
	initial begin
		adc_eoc   = 1'b0;
		drp_rdy   = 1'b0;
		drp_do    = '0;
		req_count = 0;
		eoc_cnt   = 0;
		lat_cnt   = 0;
		busy      = 1'b0;
		held_code = '0;
		forever begin
			@(negedge clk);
			adc_eoc = 1'b0;
			drp_rdy = 1'b0;

			//////////////////////////////////////////////////
			// conversions, free running once out of reset
			if (adc_reset) begin
				eoc_cnt = 0;
			end else if (eoc_cnt == EOC_PERIOD - 1) begin
				eoc_cnt = 0;
				adc_eoc = (req_count < NUM_READS);  // quiet after the table
			end else begin
				eoc_cnt = eoc_cnt + 1;
			end

			//////////////////////////////////////////////////
			// drp read port
			if (busy) begin
				lat_cnt = lat_cnt + 1;
				if (lat_cnt == EXTRA_EOC_AT)
					adc_eoc = 1'b1;              // must be ignored by the dut
				if (lat_cnt == READ_LAT) begin
					drp_rdy = 1'b1;
					drp_do  = held_code;
					busy    = 1'b0;
				end
			end else if (drp_en) begin
				busy      = 1'b1;
				lat_cnt   = 0;
				held_code = code_in;
				req_count = req_count + 1;
			end
		end
	end

endmodule

// ==== testbench/tb_xadc_monitor.sv ====
`timescale 1ns/1ps

module tb_xadc_monitor import xadc_pkg::*; ();

	localparam int CLK_PERIOD   = 20;           // ns
	localparam int RESET_CYCLES = 10;
	localparam int EOC_PERIOD   = 40;           // model conversion period
	localparam int READ_LAT     = 5;            // model read latency
	localparam int SEG_READS    = 16;           // reads per temperature range
	localparam int NUM_SEGS     = 4;
	localparam int NUM_READS    = SEG_READS * NUM_SEGS;
	localparam int NUM_SAMPLES  = NUM_READS / 2;  // every second read
	localparam int GROUP        = 1 << AVG_LOG2;
	localparam int NUM_AVGS     = NUM_SAMPLES / GROUP;
	localparam int WATCHDOG_CYCLES =
		2 * (RESET_HOLD_CYCLES + SETTLE_CYCLES + NUM_READS * EOC_PERIOD);
	localparam logic [31:0] SEED        = 32'h744b_46c9;
	localparam logic [31:0] JITTER_MASK = 32'h0000_00ff;  // low-order noise

	// cool, hot, middle band, cool
	localparam logic [CODE_W-1:0] SEG_BASE [NUM_SEGS] = '{
		16'h9000, 16'hc000, 16'hb000, 16'h9000
	};

	logic              clk;
	logic              rst_n;
	logic              adc_eoc;
	logic              drp_rdy;
	logic [CODE_W-1:0] drp_do;
	logic              adc_reset;
	logic              drp_en;
	logic              sample_valid;
	logic [CODE_W-1:0] sample_code;
	logic              avg_valid;
	logic [CODE_W-1:0] avg_code;
	logic              over_temp;
	logic [CODE_W-1:0] model_code;  // next code handed to the model
	int                req_count;

	logic [CODE_W-1:0] stim_code  [NUM_READS];    // what each read returns
	logic [CODE_W-1:0] exp_sample [NUM_SAMPLES];
	logic [CODE_W-1:0] exp_avg    [NUM_AVGS];
	logic              exp_flag   [NUM_AVGS];     // over_temp after each average

	int   en_count  = 0;
	int   smp_idx   = 0;
	int   avg_idx   = 0;
	logic busy      = 1'b0;   // read outstanding, seen from outside
	logic cur_flag  = 1'b0;   // over_temp expected right now

	assign model_code = (req_count < NUM_READS) ? stim_code[req_count] : '0;

	xadc_monitor_top UUT (
		.clk          (clk),
		.rst_n        (rst_n),
		.adc_eoc      (adc_eoc),
		.drp_rdy      (drp_rdy),
		.drp_do       (drp_do),
		.adc_reset    (adc_reset),
		.drp_en       (drp_en),
		.sample_valid (sample_valid),
		.sample_code  (sample_code),
		.avg_valid    (avg_valid),
		.avg_code     (avg_code),
		.over_temp    (over_temp)
	);

	tb_adc_model #(
		.EOC_PERIOD (EOC_PERIOD),
		.READ_LAT   (READ_LAT),
		.NUM_READS  (NUM_READS)
	) u_adc (
		.clk       (clk),
		.adc_reset (adc_reset),
		.drp_en    (drp_en),
		.code_in   (model_code),
		.adc_eoc   (adc_eoc),
		.drp_rdy   (drp_rdy),
		.drp_do    (drp_do),
		.req_count (req_count)
	);

	//////////////////////////////////////////////////
	// helpers

	task automatic abort_run();
		$display("*** FAILED ***");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_value(input logic [31:0] actual, input logic [31:0] expected,
		input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t: %s, got 0x%0h, expected 0x%0h",
				$time, what, actual, expected);
			abort_run();
		end
	endtask

	// jittered codes, then expected samples, means and flags from them
	task automatic build_expected();
		int   i;
		int   n;
		int   a;
		int   sum;
		logic flag;
		for (i = 0; i < NUM_READS; i++)
			stim_code[i] = SEG_BASE[i / SEG_READS] + CODE_W'($urandom() & JITTER_MASK);
		n = 0;
		for (i = 1; i < NUM_READS; i += 2) begin   // first read dropped
			exp_sample[n] = stim_code[i];
			n++;
		end
		flag = 1'b0;
		for (a = 0; a < NUM_AVGS; a++) begin
			sum = 0;
			for (i = 0; i < GROUP; i++)
				sum = sum + int'(exp_sample[a * GROUP + i]);
			exp_avg[a] = CODE_W'(sum / GROUP);      // floor of the mean
			if (exp_avg[a] >= TEMP_SET_CODE)
				flag = 1'b1;
			else if (exp_avg[a] <= TEMP_CLEAR_CODE)
				flag = 1'b0;
			exp_flag[a] = flag;                     // middle band holds
		end
	endtask

	//////////////////////////////////////////////////
	// clock and watchdog

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("ERROR: run timed out after %0d clock cycles", WATCHDOG_CYCLES);
		abort_run();
	end

	//////////////////////////////////////////////////
	// output monitor sampling before the edge updates

	always @(posedge clk) begin
		if (rst_n) begin
			compare_value(32'(over_temp), 32'(cur_flag), "over_temp");
			if (drp_en) begin
				compare_value(32'(busy), 0, "drp_en with a read outstanding");
				busy = 1'b1;
				en_count++;
			end
			if (drp_rdy)
				busy = 1'b0;
			if (avg_valid) begin
				compare_value(32'(avg_idx < NUM_AVGS), 1, "avg_valid beyond table");
				compare_value(smp_idx, GROUP * (avg_idx + 1), "samples per average");
				compare_value(32'(avg_code), 32'(exp_avg[avg_idx]),
					$sformatf("avg_code %0d", avg_idx));
				cur_flag = exp_flag[avg_idx];       // visible next cycle
				avg_idx++;
			end
			if (sample_valid) begin
				compare_value(32'(smp_idx < NUM_SAMPLES), 1, "sample_valid beyond table");
				compare_value(32'(sample_code), 32'(exp_sample[smp_idx]),
					$sformatf("sample_code %0d", smp_idx));
				smp_idx++;
			end
		end
	end

	//////////////////////////////////////////////////
	// main sequence

	initial begin
		int hold_cnt;
		int gap;
		void'($urandom(SEED));
		build_expected();
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		compare_value(32'(drp_en), 0, "drp_en in reset");
		compare_value(32'(sample_valid), 0, "sample_valid in reset");
		compare_value(32'(avg_valid), 0, "avg_valid in reset");
		compare_value(32'(over_temp), 0, "over_temp in reset");
		compare_value(32'(adc_reset), 1, "adc_reset in reset");
		rst_n = 1'b1;

		// adc reset hold, then settle before any read
		hold_cnt = 0;
		do begin
			@(negedge clk);
			hold_cnt++;
			compare_value(32'(drp_en), 0, "drp_en during adc reset");
		end while (adc_reset);
		compare_value(hold_cnt, RESET_HOLD_CYCLES, "adc_reset hold cycles");
		gap = 0;
		do begin
			@(negedge clk);
			gap++;
		end while (!drp_en);
		compare_value(32'(gap > SETTLE_CYCLES), 1, "drp_en before settle time");

		wait (avg_idx == NUM_AVGS);
		repeat (2 * EOC_PERIOD) @(posedge clk);   // nothing more may show up
		compare_value(en_count, NUM_READS, "drp_en pulse count");
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// ==== vlog.f ====
rtl/xadc_pkg.sv
rtl/xadc_sequencer.sv
rtl/sample_averager.sv
rtl/limit_monitor.sv
rtl/xadc_monitor_top.sv
testbench/tb_adc_model.sv
testbench/tb_xadc_monitor.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the xadc monitor testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_xadc_monitor
OBJ=obj_dir
LOG=sim.log

rm -rf "$OBJ"

verilator --binary --timing --assert -j 0 --top-module "$TOP" -Mdir "$OBJ" -f vlog.f
if [ $? -ne 0 ]; then
	echo "run.sh: compile failed"
	exit 1
fi

"./$OBJ/V$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
	echo "run.sh: simulation exited with status $sim_status"
	exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
	echo "run.sh: test passed"
	exit 0
fi
echo "run.sh: pass message not found in $LOG"
exit 1
